/* source/sat_formula_pkg.sv */
/* sat formula package
   sizes and types for literals, clauses, whole formulas and variable assignments */
package sat_formula_pkg;

    // formula dimensions
    localparam int NUM_VARS    = 8;
    localparam int VAR_BITS    = 3;
    localparam int NUM_CLAUSES = 16;
    localparam int CLAUSE_BITS = 4;
    // literals per clause, 3-sat
    localparam int NSAT        = 3;

    // one literal, 5 bits
    typedef struct packed {
        logic                valid;
        // set when the literal is the negated variable
        logic                neg;
        logic [VAR_BITS-1:0] var_idx;
    } literal_t;

    // one clause, 16 bits, literal 0 in the low bits
    typedef struct packed {
        logic                      valid;
        literal_t [NSAT-1:0]       lits;
    } clause_t;

    // whole formula, clause 0 in the low bits
    typedef clause_t [NUM_CLAUSES-1:0] clause_array_t;

    // variable values, bit n is variable n, 1 means true
    typedef logic [NUM_VARS-1:0] assign_t;

    // true when a valid literal evaluates true under the assignment
    function automatic logic lit_is_true(literal_t lit, assign_t a);
        return lit.valid & (a[lit.var_idx] ^ lit.neg);
    endfunction

endpackage

/* source/sat_search_pkg.sv */
/* sat search package
   constants and types of the local search, break values, selection and result */
package sat_search_pkg;

    import sat_formula_pkg::*;

    // a variable appears in at most 16 clauses, so 5 bits hold any break value
    localparam int BREAK_BITS = 5;
    localparam int SEL_BITS   = 2;
    // no valid literal in the clause
    localparam logic [SEL_BITS-1:0] SEL_NONE = 2'd3;

    // random word above this value takes a random walk step
    localparam logic [31:0] WALK_THRESHOLD = 32'h6E147AE0;

    // flip limit and counter width
    localparam int FLIP_BITS = 10;
    localparam logic [FLIP_BITS-1:0] MAX_FLIPS = 10'd1023;

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam logic [31:0] LFSR_SEED = 32'h1D87_2B41;

    // break values of the target clause, literal 0 in the low bits
    typedef struct packed {
        logic [NSAT-1:0][BREAK_BITS-1:0] value;
        logic [NSAT-1:0]                 valid;
    } break_vec_t;

    typedef struct packed {
        logic [SEL_BITS-1:0] idx;
        // choice came from a random walk step
        logic                walk;
    } selection_t;

    typedef struct packed {
        logic                 sat;
        assign_t              assignment;
        logic [FLIP_BITS-1:0] flips;
    } result_t;

endpackage

/* source/lfsr_32.sv */
/* lfsr_32
   32-bit galois lfsr, one new random word per search step */
`timescale 1ns/1ps

module lfsr_32 import sat_search_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        step_i,
    output logic [31:0] rnd_o
);

    logic [31:0] lfsr_q;

    // shift right, feed the dropped bit back into the tap positions
    always_ff @(posedge clk) begin
        if (rst_i) begin
            lfsr_q <= LFSR_SEED;
        end else if (step_i) begin
            if (lfsr_q[0]) begin
                lfsr_q <= {1'b0, lfsr_q[31:1]} ^ LFSR_TAPS;
            end else begin
                lfsr_q <= {1'b0, lfsr_q[31:1]};
            end
        end
    end

    // nonzero seed keeps it out of the lock-up state
    assign rnd_o = lfsr_q;

endmodule

/* source/clause_store.sv */
/* clause store
   clause register file with a write port and a search for the first unsatisfied clause */
`timescale 1ns/1ps

module clause_store import sat_formula_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_i,
    // host write port
    input  logic                   load_i,
    input  logic [CLAUSE_BITS-1:0] load_addr_i,
    input  clause_t                load_clause_i,
    // current assignment from the controller
    input  assign_t                assign_i,
    output clause_array_t          clauses_o,
    output logic                   all_sat_o,
    output clause_t                unsat_clause_o
);

    clause_array_t           clauses_q;
    logic [NUM_CLAUSES-1:0]  clause_sat;
    logic [CLAUSE_BITS-1:0]  unsat_idx;

    // all slots come out of reset invalid, so an unloaded slot is ignored
    always_ff @(posedge clk) begin
        if (rst_i) begin
            clauses_q <= '0;
        end else if (load_i) begin
            clauses_q[load_addr_i] <= load_clause_i;
        end
    end

    // evaluate every clause against the assignment
    always_comb begin
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            // invalid clause counts as satisfied
            clause_sat[c] = ~clauses_q[c].valid;
            for (int l = 0; l < NSAT; l++) begin
                if (lit_is_true(clauses_q[c].lits[l], assign_i)) begin
                    clause_sat[c] = 1'b1;
                end
            end
        end
    end

    // priority search, lowest unsatisfied clause wins
    always_comb begin
        unsat_idx = '0;
        // scan downward so the last hit is the lowest index
        for (int c = NUM_CLAUSES - 1; c >= 0; c--) begin
            if (!clause_sat[c]) begin
                unsat_idx = CLAUSE_BITS'(c);
            end
        end
    end

    assign all_sat_o = &clause_sat;

    // only meaningful while all_sat_o is low
    assign unsat_clause_o = clauses_q[unsat_idx];

    // whole formula goes to the break counter
    assign clauses_o = clauses_q;

endmodule

/* source/break_counter.sv */
/* break counter
   break values of the target clause literals against every stored clause */
`timescale 1ns/1ps

module break_counter
    import sat_formula_pkg::*;
    import sat_search_pkg::*;
(
    input  clause_array_t clauses_i,
    input  assign_t       assign_i,
    // lowest unsatisfied clause
    input  clause_t       target_i,
    output break_vec_t    breaks_o
);

    // clause is held true by exactly one literal
    logic [NUM_CLAUSES-1:0] single_true;
    // variable of that one true literal
    logic [VAR_BITS-1:0]    true_var [NUM_CLAUSES];
    logic [NSAT-1:0][BREAK_BITS-1:0] break_cnt;

    // per clause, count true literals and remember the last true variable
    always_comb begin
        int unsigned n_true;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            n_true      = 0;
            true_var[c] = '0;
            for (int l = 0; l < NSAT; l++) begin
                if (lit_is_true(clauses_i[c].lits[l], assign_i)) begin
                    n_true      = n_true + 1;
                    true_var[c] = clauses_i[c].lits[l].var_idx;
                end
            end
            single_true[c] = clauses_i[c].valid && (n_true == 1);
        end
    end

    // a clause breaks when its only true literal sits on the flipped variable
    always_comb begin
        for (int k = 0; k < NSAT; k++) begin
            break_cnt[k] = '0;
            if (target_i.lits[k].valid) begin
                for (int c = 0; c < NUM_CLAUSES; c++) begin
                    if (single_true[c] && (true_var[c] == target_i.lits[k].var_idx)) begin
                        break_cnt[k] = break_cnt[k] + BREAK_BITS'(1);
                    end
                end
            end
        end
    end

    // the target clause is false, so its own literals never add to the count
    assign breaks_o.value = break_cnt;

    // literal valid bits pass straight to the selector
    always_comb begin
        for (int k = 0; k < NSAT; k++) begin
            breaks_o.valid[k] = target_i.lits[k].valid;
        end
    end

endmodule

/* source/heuristic_selector.sv */
/* heuristic selector
   walksat choice among up to three literals, zero break first, then random walk or min break */
`timescale 1ns/1ps

module heuristic_selector
    import sat_formula_pkg::*;
    import sat_search_pkg::*;
(
    input  break_vec_t  breaks_i,
    input  logic [31:0] random_i,
    output selection_t  select_o
);

    logic [BREAK_BITS-1:0] bv [NSAT];
    logic [NSAT-1:0]       valid;
    logic [NSAT-1:0]       is_zero;
    logic                  has_zero;
    logic                  random_walk;
    logic [1:0]            num_valid;
    // lowest and highest valid literal, used when exactly two are valid
    logic [SEL_BITS-1:0]   lo_idx;
    logic [SEL_BITS-1:0]   hi_idx;
    logic [SEL_BITS-1:0]   zero_idx;
    logic [SEL_BITS-1:0]   min3_idx;

    assign valid = breaks_i.valid;

    always_comb begin
        for (int k = 0; k < NSAT; k++) begin
            bv[k]      = breaks_i.value[k];
            // only valid literals can claim a zero break
            is_zero[k] = valid[k] && (breaks_i.value[k] == '0);
        end
    end

    assign has_zero    = |is_zero;
    assign random_walk = random_i > WALK_THRESHOLD;

    // count valid literals and locate the outer two
    always_comb begin
        num_valid = '0;
        lo_idx    = SEL_NONE;
        hi_idx    = SEL_NONE;
        zero_idx  = SEL_NONE;
        for (int k = 0; k < NSAT; k++) begin
            if (valid[k]) begin
                num_valid = num_valid + 2'd1;
                hi_idx    = SEL_BITS'(k);
                if (lo_idx == SEL_NONE) begin
                    lo_idx = SEL_BITS'(k);
                end
            end
            // ascending scan, highest zero-break literal wins
            if (is_zero[k]) begin
                zero_idx = SEL_BITS'(k);
            end
        end
    end

    // greedy pick over three literals
    // literal 0 only on a strict win, ties between 1 and 2 go to 2
    always_comb begin
        if (bv[0] < bv[1] && bv[0] < bv[2]) begin
            min3_idx = 2'd0;
        end else if (bv[2] <= bv[0] && bv[2] <= bv[1]) begin
            min3_idx = 2'd2;
        end else begin
            min3_idx = 2'd1;
        end
    end

    always_comb begin
        select_o.idx  = SEL_NONE;
        select_o.walk = 1'b0;
        if (num_valid == 2'd0) begin
            select_o.idx = SEL_NONE;
        end else if (has_zero) begin
            select_o.idx = zero_idx;
        end else if (num_valid == 2'd1) begin
            // single literal, nothing to choose
            select_o.idx = lo_idx;
        end else if (random_walk) begin
            select_o.walk = 1'b1;
            if (num_valid == 2'd2) begin
                select_o.idx = random_i[7] ? hi_idx : lo_idx;
            end else begin
                select_o.idx = SEL_BITS'(random_i[5:0] % NSAT);
            end
        end else if (num_valid == 2'd2) begin
            // ties go to the higher literal
            select_o.idx = (bv[lo_idx] < bv[hi_idx]) ? lo_idx : hi_idx;
        end else begin
            select_o.idx = min3_idx;
        end
    end

endmodule

/* source/walksat_controller.sv */
/* walksat controller
   search fsm holding the assignment, the flip counter and the reported result */
`timescale 1ns/1ps

module walksat_controller
    import sat_formula_pkg::*;
    import sat_search_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic       start_i,
    input  logic       all_sat_i,
    input  clause_t    unsat_clause_i,
    input  selection_t select_i,
    output assign_t    assign_o,
    output logic       step_o,
    output logic       busy_o,
    output logic       done_o,
    output result_t    result_o
);

    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        FLIP,
        DONE
    } state_t;

    state_t               state_q;
    assign_t              assign_q;
    logic [FLIP_BITS-1:0] flips_q;
    literal_t             flip_lit;
    logic                 flip_en;

    // literal named by the selector, none for the sentinel index
    assign flip_lit = (select_i.idx < SEL_BITS'(NSAT)) ? unsat_clause_i.lits[select_i.idx] : '0;
    assign flip_en  = flip_lit.valid;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q  <= IDLE;
            assign_q <= '0;
            flips_q  <= '0;
            done_o   <= 1'b0;
            result_o <= '0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    // every search starts from all false
                    if (start_i) begin
                        assign_q <= '0;
                        flips_q  <= '0;
                        state_q  <= CHECK;
                    end
                end
                CHECK: begin
                    if (all_sat_i || flips_q == MAX_FLIPS) begin
                        state_q <= DONE;
                    end else begin
                        state_q <= FLIP;
                    end
                end
                FLIP: begin
                    if (flip_en) begin
                        assign_q[flip_lit.var_idx] <= ~assign_q[flip_lit.var_idx];
                    end
                    // counted even without a literal so the search always ends
                    flips_q <= flips_q + FLIP_BITS'(1);
                    state_q <= CHECK;
                end
                default: begin
                    // assignment unchanged since CHECK, all_sat still holds
                    result_o.sat        <= all_sat_i;
                    result_o.assignment <= assign_q;
                    result_o.flips      <= flips_q;
                    done_o              <= 1'b1;
                    state_q             <= IDLE;
                end
            endcase
        end
    end

    assign assign_o = assign_q;
    // lfsr moves on once per flip
    assign step_o   = (state_q == FLIP);
    assign busy_o   = (state_q != IDLE);

endmodule

/* source/walksat_top.sv */
/* walksat top
   clause store, break counter, selector, lfsr and controller wired together */
`timescale 1ns/1ps

module walksat_top
    import sat_formula_pkg::*;
    import sat_search_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   load_i,
    input  logic [CLAUSE_BITS-1:0] load_addr_i,
    input  clause_t                load_clause_i,
    input  logic                   start_i,
    output logic                   busy_o,
    output logic                   done_o,
    output result_t                result_o
);

    clause_array_t clauses;
    assign_t       assignment;
    logic          all_sat;
    clause_t       unsat_clause;
    break_vec_t    breaks;
    logic [31:0]   rnd;
    selection_t    selection;
    logic          step;

    clause_store i_store (
        .clk            (clk),
        .rst_i          (rst_i),
        .load_i         (load_i),
        .load_addr_i    (load_addr_i),
        .load_clause_i  (load_clause_i),
        .assign_i       (assignment),
        .clauses_o      (clauses),
        .all_sat_o      (all_sat),
        .unsat_clause_o (unsat_clause)
    );

    // break values of the first unsatisfied clause
    break_counter i_break (
        .clauses_i (clauses),
        .assign_i  (assignment),
        .target_i  (unsat_clause),
        .breaks_o  (breaks)
    );

    heuristic_selector i_sel (
        .breaks_i (breaks),
        .random_i (rnd),
        .select_o (selection)
    );

    lfsr_32 i_lfsr (
        .clk    (clk),
        .rst_i  (rst_i),
        .step_i (step),
        .rnd_o  (rnd)
    );

    walksat_controller i_ctrl (
        .clk            (clk),
        .rst_i          (rst_i),
        .start_i        (start_i),
        .all_sat_i      (all_sat),
        .unsat_clause_i (unsat_clause),
        .select_i       (selection),
        .assign_o       (assignment),
        .step_o         (step),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .result_o       (result_o)
    );

endmodule

/* verification/walksat_sva.sv */
/* walksat controller assertions
   done pulse width, flip bounds, idle stability and single-variable flips */
`timescale 1ns/1ps

module walksat_sva
    import sat_formula_pkg::*;
    import sat_search_pkg::*;
(
    input logic                 clk,
    input logic                 rst_i,
    input logic                 start_i,
    input logic                 busy_o,
    input logic                 done_o,
    input logic                 step_o,
    input logic                 flip_en,
    input assign_t              assign_o,
    input logic [FLIP_BITS-1:0] flips_q
);

    // done is a one-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (rst_i) done_o |=> !done_o)
        else $error("done_o held high for more than one cycle");

    // no flip is taken at the limit, so the counter never passes MAX_FLIPS
    flip_bound: assert property (@(posedge clk) disable iff (rst_i)
        step_o |-> (flips_q < MAX_FLIPS))
        else $error("flip taken with the flip count at the limit");

    // idle without a start leaves the assignment alone
    idle_stable: assert property (@(posedge clk) disable iff (rst_i)
        (!busy_o && !start_i) |=> $stable(assign_o))
        else $error("assignment changed while the solver was idle");

    // a flip with a valid literal touches exactly one variable
    one_flip: assert property (@(posedge clk) disable iff (rst_i)
        (step_o && flip_en) |=> $onehot(assign_o ^ $past(assign_o)))
        else $error("flip did not change exactly one variable");

endmodule

bind walksat_controller walksat_sva i_sva (
    .clk      (clk),
    .rst_i    (rst_i),
    .start_i  (start_i),
    .busy_o   (busy_o),
    .done_o   (done_o),
    .step_o   (step_o),
    .flip_en  (flip_en),
    .assign_o (assign_o),
    .flips_q  (flips_q)
);

/* verification/walksat_tb.sv */
/* walksat testbench
   loads a table of formulas, runs the solver on each and checks the reported results */
`timescale 1ns/1ps

module walksat_tb
    import sat_formula_pkg::*;
    import sat_search_pkg::*;
();

    localparam int NUM_ROWS       = 7;
    localparam int RESET_CYCLES   = 16;
    localparam int LOAD_CYCLES    = NUM_CLAUSES + 8;
    // worst case per row is a search that runs into the flip limit
    localparam int ROW_CYCLES     = 2 * int'(MAX_FLIPS) + 3 + LOAD_CYCLES;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * ROW_CYCLES + 32;
    // unit row, one forced value per variable
    localparam assign_t  UNIT_PATTERN = 8'hAD;
    localparam literal_t NO_LIT       = '0;

    typedef enum logic {SOLVABLE, FLIP_LIMIT} kind_t;

    // one table row, the formula and what the run must report
    typedef struct packed {
        clause_array_t formula;
        kind_t         kind;
        result_t       want;
        // result fields compared exactly
        result_t       care;
    } row_t;

    logic                   clk;
    logic                   rst_i;
    logic                   load_i;
    logic [CLAUSE_BITS-1:0] load_addr_i;
    clause_t                load_clause_i;
    logic                   start_i;
    logic                   busy_o;
    logic                   done_o;
    result_t                result_o;

    row_t   rows [NUM_ROWS];
    integer seed = 32'h438b;

    walksat_top i_dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .load_i        (load_i),
        .load_addr_i   (load_addr_i),
        .load_clause_i (load_clause_i),
        .start_i       (start_i),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .result_o      (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog sized from the table length
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("solver never signalled done within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic fail_now(string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_result(result_t got, result_t want, result_t care, int row);
        if (((got ^ want) & care) !== '0) begin
            fail_now($sformatf("row %0d result sat %0b assign %02h flips %0d, want %0b %02h %0d",
                row, got.sat, got.assignment, got.flips, want.sat, want.assignment, want.flips));
        end
    endtask

    task automatic check_clause(clause_t got, clause_t want, int slot);
        if (got !== want) begin
            fail_now($sformatf("slot %0d holds clause %04h, want %04h", slot, got, want));
        end
    endtask

    function automatic literal_t make_lit(int v, logic n);
        literal_t lit;
        lit.valid   = 1'b1;
        lit.neg     = n;
        lit.var_idx = VAR_BITS'(v);
        return lit;
    endfunction

    function automatic clause_t make_clause(literal_t a, literal_t b, literal_t c);
        clause_t cl;
        cl.valid   = 1'b1;
        cl.lits[0] = a;
        cl.lits[1] = b;
        cl.lits[2] = c;
        return cl;
    endfunction

    // own clause evaluation, an invalid clause holds trivially
    function automatic logic clause_holds(clause_t cl, assign_t a);
        logic hit;
        hit = ~cl.valid;
        for (int l = 0; l < NSAT; l++) begin
            if (cl.lits[l].valid && (a[cl.lits[l].var_idx] != cl.lits[l].neg)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // random 3-literal clauses, each one kept true by a hidden assignment
    task automatic plant_formula(int n_clauses, output clause_array_t f);
        assign_t     planted;
        logic [31:0] rnd;
        int          v [NSAT];
        int          keep;
        f       = '0;
        rnd     = $random(seed);
        planted = rnd[NUM_VARS-1:0];
        for (int c = 0; c < n_clauses; c++) begin
            v[0] = {$random(seed)} % NUM_VARS;
            do v[1] = {$random(seed)} % NUM_VARS; while (v[1] == v[0]);
            do v[2] = {$random(seed)} % NUM_VARS; while (v[2] == v[0] || v[2] == v[1]);
            keep = {$random(seed)} % NSAT;
            f[c].valid = 1'b1;
            for (int l = 0; l < NSAT; l++) begin
                rnd = $random(seed);
                f[c].lits[l] = make_lit(v[l], (l == keep) ? ~planted[v[l]] : rnd[0]);
            end
        end
    endtask

    task automatic build_table();
        result_t sat_only;
        sat_only     = '0;
        sat_only.sat = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            rows[r]          = '0;
            rows[r].kind     = SOLVABLE;
            rows[r].want.sat = 1'b1;
            rows[r].care     = sat_only;
        end
        // row 0 already holds under all false, zero flips
        rows[0].formula[0] = make_clause(make_lit(0, 1), make_lit(1, 0), make_lit(2, 1));
        rows[0].formula[1] = make_clause(make_lit(3, 1), NO_LIT, NO_LIT);
        rows[0].formula[2] = make_clause(make_lit(4, 1), make_lit(5, 1), NO_LIT);
        rows[0].formula[3] = make_clause(make_lit(6, 0), make_lit(7, 1), make_lit(5, 0));
        rows[0].care       = '1;
        plant_formula(16, rows[1].formula);
        plant_formula(12, rows[2].formula);
        // every sign pattern over x0..x2, no model exists
        for (int s = 0; s < 8; s++) begin
            rows[3].formula[s] = make_clause(make_lit(0, s[0]), make_lit(1, s[1]),
                                             make_lit(2, s[2]));
        end
        rows[3].kind       = FLIP_LIMIT;
        rows[3].want.sat   = 1'b0;
        rows[3].want.flips = MAX_FLIPS;
        rows[3].care.flips = '1;
        // unit on each variable, one flip per true unit, reuses the unsat slots
        for (int v = 0; v < NUM_VARS; v++) begin
            rows[4].formula[v] = make_clause(make_lit(v, ~UNIT_PATTERN[v]), NO_LIT, NO_LIT);
        end
        rows[4].want.assignment = UNIT_PATTERN;
        rows[4].want.flips      = FLIP_BITS'($countones(UNIT_PATTERN));
        rows[4].care            = '1;
        // units mixed with two-literal implications
        rows[5].formula[0] = make_clause(make_lit(1, 0), NO_LIT, NO_LIT);
        rows[5].formula[1] = make_clause(make_lit(2, 1), NO_LIT, NO_LIT);
        rows[5].formula[2] = make_clause(make_lit(1, 1), make_lit(4, 0), NO_LIT);
        rows[5].formula[3] = make_clause(make_lit(2, 0), make_lit(6, 0), NO_LIT);
        rows[5].formula[4] = make_clause(make_lit(0, 0), make_lit(3, 0), NO_LIT);
        rows[5].formula[5] = make_clause(make_lit(4, 1), make_lit(7, 0), NO_LIT);
        rows[5].formula[6] = make_clause(make_lit(6, 1), make_lit(5, 0), NO_LIT);
        plant_formula(16, rows[6].formula);
    endtask

    // writes all slots, so a shorter formula clears the old one
    task automatic load_formula(clause_array_t f);
        for (int a = 0; a < NUM_CLAUSES; a++) begin
            @(posedge clk);
            load_i        <= 1'b1;
            load_addr_i   <= CLAUSE_BITS'(a);
            load_clause_i <= f[a];
        end
        @(posedge clk);
        load_i <= 1'b0;
        @(negedge clk);
        for (int a = 0; a < NUM_CLAUSES; a++) begin
            check_clause(i_dut.clauses[a], f[a], a);
        end
    endtask

    task automatic run_row(int r);
        int cycles;
        load_formula(rows[r].formula);
        @(posedge clk);
        start_i <= 1'b1;
        cycles = 0;
        // count edges from the start drive until done shows up
        do begin
            @(posedge clk);
            start_i <= 1'b0;
            cycles++;
            @(negedge clk);
        end while (!done_o);
        check_result(result_o, rows[r].want, rows[r].care, r);
        if (rows[r].kind == SOLVABLE) begin
            for (int c = 0; c < NUM_CLAUSES; c++) begin
                if (!clause_holds(rows[r].formula[c], result_o.assignment)) begin
                    fail_now($sformatf("row %0d assignment %02h leaves clause %0d false",
                        r, result_o.assignment, c));
                end
            end
        end
        // two cycles per flip plus start, check and done
        if (cycles != 2 * int'(result_o.flips) + 3) begin
            fail_now($sformatf("row %0d done after %0d cycles for %0d flips",
                r, cycles, result_o.flips));
        end
        $display("row %0d: sat %0b flips %0d cycles %0d", r, result_o.sat, result_o.flips, cycles);
    endtask

    initial begin
        rst_i         = 1'b1;
        load_i        = 1'b0;
        load_addr_i   = '0;
        load_clause_i = '0;
        start_i       = 1'b0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        if (busy_o !== 1'b0 || done_o !== 1'b0) begin
            fail_now("busy_o or done_o set after reset");
        end
        check_result(result_o, '0, '1, -1);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* flist.f */
source/sat_formula_pkg.sv
source/sat_search_pkg.sv
source/lfsr_32.sv
source/clause_store.sv
source/break_counter.sv
source/heuristic_selector.sv
source/walksat_controller.sv
source/walksat_top.sv
verification/walksat_sva.sv
verification/walksat_tb.sv

/* Makefile */
# Verilator build and run of the walksat testbench
TOP := walksat_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the simulation with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
